/* Makefile */
# Verilator build, run, lint and clean for the clock controller

TOP := clock_ctrl_tb

.PHONY: all run lint clean

all: run

# Pass only when the testbench prints its pass line
run:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f project.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Everything OK" > /dev/null

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir

/* dv/clock_ctrl_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl_tb;

//---------------------------------------------------------------------------
// Timing and limits
//---------------------------------------------------------------------------
	localparam int n_ch          = clock_ctrl_pkg::num_dps;
	localparam int n_mon         = clock_ctrl_pkg::num_mon;
	localparam int clk_half_ns   = 10;					// 20 ns clock
	localparam int drive_ns      = 2;					// Input skew after rising edge
	localparam int max_pll_delay = 4;					// Done 1-4 cycles after en
	localparam int cyc_per_step  = 3 + max_pll_delay;	// Step, wait, check, slack
	localparam int num_fires     = 10;					// Serial fire sequences in the run
	localparam int idle_limit    = clock_ctrl_pkg::steps_per_cycle * cyc_per_step + 20;
	localparam longint watchdog_ns = longint'(num_fires) * clock_ctrl_pkg::steps_per_cycle
		* cyc_per_step * 2 * clk_half_ns + 200_000;

//---------------------------------------------------------------------------
// DUT signals
//---------------------------------------------------------------------------
	logic clock = 1'b0;
	logic rst_n = 1'b0;
	clock_ctrl_pkg::dps_ctrl_t [n_ch-1:0] dps_ctrl = '0;
	clock_ctrl_pkg::dps_stat_t [n_ch-1:0] dps_stat;
	clock_ctrl_pkg::ps_cmd_t   [n_ch-1:0] ps_cmd;
	logic [n_ch-1:0]  ps_done = '0;		// From PLL model
	logic [n_ch-1:0]  dps_lock = '1;	// Channel PLLs locked throughout
	logic             lock_main = 1'b0;
	logic             global_reset_en = 1'b0;
	logic             global_reset;
	logic             clock_lock_lost_err;
	logic [n_mon-1:0] spare_clocks;
	logic [n_mon-1:0] spare_lock;

	logic             spare_wave = 1'b0;	// Clock-rate square wave between the edges
	logic [n_mon-1:0] spare_run = '0;		// Lanes carrying the wave
	logic [n_mon-1:0] spare_level = '0;		// Stuck level of other lanes

	always #clk_half_ns clock = ~clock;
	always @(clock) #5 spare_wave = ~spare_wave;	// Toggles midway between edges

	assign spare_clocks = ({n_mon{spare_wave}} & spare_run) | (spare_level & ~spare_run);

	clock_ctrl uut (
		.clock               (clock),
		.rst_n               (rst_n),
		.dps_ctrl            (dps_ctrl),
		.dps_stat            (dps_stat),
		.ps_cmd              (ps_cmd),
		.ps_done             (ps_done),
		.dps_lock            (dps_lock),
		.lock_main           (lock_main),
		.global_reset_en     (global_reset_en),
		.global_reset        (global_reset),
		.clock_lock_lost_err (clock_lock_lost_err),
		.spare_clocks        (spare_clocks),
		.spare_lock          (spare_lock)
	);

//---------------------------------------------------------------------------
// PLL step model and pulse counters
//---------------------------------------------------------------------------
	int              seed = 32'h8f91_29ac;
	int              wait_cnt [n_ch] = '{default: 0};	// Cycles until done
	int              inc_cnt  [n_ch] = '{default: 0};	// Increment pulses seen
	int              dec_cnt  [n_ch] = '{default: 0};	// Decrement pulses seen
	logic [n_ch-1:0] pll_busy = '0;						// Step in flight

	always @(posedge clock) begin
		logic [n_ch-1:0] done_next;
		#drive_ns;
		done_next = '0;
		for (int c = 0; c < n_ch; c++) begin
			if (wait_cnt[c] > 0) begin
				wait_cnt[c] = wait_cnt[c] - 1;
				done_next[c] = (wait_cnt[c] == 0);	// One-cycle done
			end
			pll_busy[c] = (wait_cnt[c] != 0) || done_next[c];	// Before this cycle's en
			if (ps_cmd[c].en) begin
				if (ps_cmd[c].incdec) begin
					inc_cnt[c] = inc_cnt[c] + 1;
				end else begin
					dec_cnt[c] = dec_cnt[c] + 1;
				end
				wait_cnt[c] = 1 + ($random(seed) & 3);	// 1 to 4 cycles
			end
		end
		ps_done = done_next;
	end

//---------------------------------------------------------------------------
// Checks
//---------------------------------------------------------------------------
	logic            chk_valid = 1'b0;	// Value compare this edge
	int              chk_exp = 0;
	int              chk_act = 0;
	string           chk_name = "";
	string           cur_test = "";
	int              err_count = 0;		// Assertion failures
	int              stall_count = 0;	// Waits that ran out
	int              check_count = 0;
	logic [n_ch-1:0] chan_live = '0;	// Channel released and settled
	logic [n_ch-1:0] idle_bad;
	logic [n_ch-1:0] step_bad;

	always_comb begin
		for (int c = 0; c < n_ch; c++) begin
			idle_bad[c] = chan_live[c] && !dps_stat[c].busy
				&& dps_stat[c].state != clock_ctrl_pkg::st_idle;
			step_bad[c] = ps_cmd[c].en && pll_busy[c];	// En before done came back
		end
	end

	a_value : assert property (@(posedge clock) chk_valid |-> chk_act == chk_exp)
		else begin
			err_count = err_count + 1;
			$display("ERR %s %s expected %0d actual %0d", cur_test, chk_name, chk_exp,
				chk_act);
		end

	a_release : assert property (@(posedge clock) disable iff (!rst_n)
		lock_main |=> !global_reset)
		else begin
			err_count = err_count + 1;
			$display("global_reset stayed high after lock_main was high");
		end

	a_refire : assert property (@(posedge clock) disable iff (!rst_n)
		(!lock_main && global_reset_en) |=> global_reset)
		else begin
			err_count = err_count + 1;
			$display("global_reset did not rise after lock loss with re-fire enabled");
		end

	a_no_refire : assert property (@(posedge clock) disable iff (!rst_n)
		(!lock_main && !global_reset_en && !global_reset) |=> !global_reset)
		else begin
			err_count = err_count + 1;
			$display("global_reset rose on lock loss with re-fire disabled");
		end

	// Lost-lock flag follows reset and lock directly
	a_lost_flag : assert property (@(posedge clock) disable iff (!rst_n)
		clock_lock_lost_err == (!global_reset && !lock_main))
		else begin
			err_count = err_count + 1;
			$display("clock_lock_lost_err does not match global_reset and lock_main");
		end

	a_idle_state : assert property (@(posedge clock) disable iff (!rst_n) idle_bad == '0)
		else begin
			err_count = err_count + 1;
			$display("A settled channel shows a state other than idle with busy low");
		end

	a_step_wait : assert property (@(posedge clock) disable iff (!rst_n) step_bad == '0)
		else begin
			err_count = err_count + 1;
			$display("A channel sent a step before the PLL returned done");
		end

//---------------------------------------------------------------------------
// Stimulus helpers
//---------------------------------------------------------------------------
	int                         test_errs0 = 0;
	int                         test_chks0 = 0;
	int                         test_count = 0;
	clock_ctrl_pkg::phase_req_t fire_req [n_ch];	// Phase per channel for next fire

	task automatic next_cycle();
		@(posedge clock);
		#drive_ns;
	endtask

	// Nearest fine step of r*1400/256 with halves rounded up
	function automatic int fine_phase(input int r);
		return (r * 1400 + 128) / 256;
	endfunction

	function automatic logic [n_ch-1:0] one_hot(input int c);
		one_hot = '0;
		one_hot[c] = 1'b1;
	endfunction

	task automatic expect_value(input string name, input int exp, input int act);
		chk_name = name;
		chk_exp = exp;
		chk_act = act;
		chk_valid = 1'b1;
		check_count = check_count + 1;
		next_cycle();				// Assertion looks at it on this edge
		chk_valid = 1'b0;
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_errs0 = err_count + stall_count;
		test_chks0 = check_count;
	endtask

	task automatic end_test();
		test_count = test_count + 1;
		$display("test %s: %0d checks, %0d errors", cur_test, check_count - test_chks0,
			err_count + stall_count - test_errs0);
	endtask

	task automatic wait_idle(input int c);
		int cycles;
		cycles = 0;
		while ((dps_stat[c].busy || dps_stat[c].state != clock_ctrl_pkg::st_idle)
			&& cycles < idle_limit) begin
			next_cycle();
			cycles = cycles + 1;
		end
		if (dps_stat[c].busy || dps_stat[c].state != clock_ctrl_pkg::st_idle) begin
			stall_count = stall_count + 1;
			$display("Channel %0d did not return to idle in time during %s", c, cur_test);
		end
	endtask

	// Reset level held two cycles before the wait for idle
	task automatic reset_channels(input logic [n_ch-1:0] mask);
		chan_live = chan_live & ~mask;
		for (int c = 0; c < n_ch; c++) begin
			if (mask[c]) dps_ctrl[c].reset = 1'b1;
		end
		next_cycle();
		next_cycle();
		for (int c = 0; c < n_ch; c++) begin
			if (mask[c]) dps_ctrl[c].reset = 1'b0;
		end
		for (int c = 0; c < n_ch; c++) begin
			if (mask[c]) wait_idle(c);
		end
		chan_live = chan_live | mask;
	endtask

	task automatic fire_mask(input logic [n_ch-1:0] mask);
		for (int c = 0; c < n_ch; c++) begin
			if (mask[c]) begin
				dps_ctrl[c].phase = fire_req[c];
				dps_ctrl[c].fire = 1'b1;
			end
		end
		next_cycle();				// Single-cycle strobe
		for (int c = 0; c < n_ch; c++) begin
			dps_ctrl[c].fire = 1'b0;
		end
	endtask

	task automatic fire_channel(input int c, input int r);
		fire_req[c] = clock_ctrl_pkg::phase_req_t'(r);
		fire_mask(one_hot(c));
	endtask

//---------------------------------------------------------------------------
// Tests
//---------------------------------------------------------------------------
	initial begin : stimulus
		int base_inc;
		int base_dec;
		int base_inc_v [n_ch];
		int base_dec_v [n_ch];
		int up_req [4];
		int up_steps [4];
		int total_err;
		up_req = '{0, 1, 128, 255};
		up_steps = '{0, 5, 700, 1395};	// Table values of the rounding rule
		for (int c = 0; c < n_ch; c++) fire_req[c] = '0;

		begin_test("reset_startup");
		repeat (3) @(posedge clock);
		#drive_ns;
		rst_n = 1'b1;
		repeat (4) next_cycle();
		expect_value("reset_before_lock", 1, int'(global_reset));	// Never locked yet
		lock_main = 1'b1;
		next_cycle();
		expect_value("reset_on_lock", 0, int'(global_reset));
		global_reset_en = 1'b1;
		lock_main = 1'b0;
		next_cycle();
		expect_value("reset_refire", 1, int'(global_reset));
		lock_main = 1'b1;
		next_cycle();
		expect_value("reset_relock", 0, int'(global_reset));
		global_reset_en = 1'b0;
		lock_main = 1'b0;
		next_cycle();
		next_cycle();
		expect_value("reset_no_refire", 0, int'(global_reset));
		expect_value("lock_lost_flag", 1, int'(clock_lock_lost_err));
		lock_main = 1'b1;
		next_cycle();
		expect_value("lock_lost_clear", 0, int'(clock_lock_lost_err));
		global_reset_en = 1'b1;
		end_test();

		begin_test("up_steps");
		for (int i = 0; i < 4; i++) begin
			reset_channels(one_hot(0));
			base_inc = inc_cnt[0];
			base_dec = dec_cnt[0];
			fire_channel(0, up_req[i]);
			wait_idle(0);
			expect_value($sformatf("up_%0d_inc", up_req[i]), up_steps[i], inc_cnt[0] - base_inc);
			expect_value($sformatf("up_%0d_dec", up_req[i]), 0, dec_cnt[0] - base_dec);
		end
		end_test();

		begin_test("down_steps");
		reset_channels(one_hot(1));
		fire_channel(1, 200);
		wait_idle(1);
		base_inc = inc_cnt[1];
		base_dec = dec_cnt[1];
		fire_channel(1, 64);		// Lower than before
		wait_idle(1);
		expect_value("down_dec", fine_phase(200) - fine_phase(64), dec_cnt[1] - base_dec);
		expect_value("down_inc", 0, inc_cnt[1] - base_inc);
		end_test();

		begin_test("ignored_fire");
		reset_channels(one_hot(2));
		base_inc = inc_cnt[2];
		base_dec = dec_cnt[2];
		fire_channel(2, 100);
		expect_value("ignored_busy", 1, int'(dps_stat[2].busy));
		fire_channel(2, 10);		// Arrives mid-shift and is dropped
		wait_idle(2);
		expect_value("ignored_inc", fine_phase(100), inc_cnt[2] - base_inc);
		expect_value("ignored_dec", 0, dec_cnt[2] - base_dec);
		reset_channels(one_hot(2));	// Tracked phase back to zero
		base_inc = inc_cnt[2];
		base_dec = dec_cnt[2];
		fire_channel(2, 20);
		wait_idle(2);
		expect_value("rezero_inc", fine_phase(20), inc_cnt[2] - base_inc);
		expect_value("rezero_dec", 0, dec_cnt[2] - base_dec);
		end_test();

		begin_test("all_channels");
		reset_channels('1);
		for (int c = 0; c < n_ch; c++) begin
			base_inc_v[c] = inc_cnt[c];
			base_dec_v[c] = dec_cnt[c];
			fire_req[c] = clock_ctrl_pkg::phase_req_t'(23 + 27 * c);
		end
		fire_mask('1);				// Same cycle on every channel
		for (int c = 0; c < n_ch; c++) wait_idle(c);
		for (int c = 0; c < n_ch; c++) begin
			expect_value($sformatf("all_ch%0d_inc", c), fine_phase(23 + 27 * c),
				inc_cnt[c] - base_inc_v[c]);
			expect_value($sformatf("all_ch%0d_dec", c), 0, dec_cnt[c] - base_dec_v[c]);
		end
		end_test();

		begin_test("spare_monitor");
		spare_run = 7'b0110101;
		spare_level = 7'b1000010;	// Stuck lanes mixed high and low
		repeat (3) next_cycle();
		expect_value("spare_mix_a", 'h35, int'(spare_lock));
		spare_run = 7'b1001010;
		spare_level = 7'b0100001;
		repeat (3) next_cycle();
		expect_value("spare_mix_b", 'h4a, int'(spare_lock));
		spare_run = '0;
		spare_level = '1;
		repeat (3) next_cycle();
		expect_value("spare_all_high", 0, int'(spare_lock));
		spare_run = '1;
		repeat (3) next_cycle();
		expect_value("spare_all_run", 'h7f, int'(spare_lock));
		end_test();

		total_err = err_count + stall_count;
		$display("%0d tests, %0d checks, %0d errors", test_count, check_count, total_err);
		if (total_err == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	end

	initial begin : watchdog
		#(watchdog_ns);
		$display("Watchdog expired before the tests finished");
		$display("Something failed");
		$finish;
	end

endmodule

`default_nettype wire

/* project.f */
source/clock_ctrl_pkg.sv
source/phase_shifter.sv
source/startup_reset.sv
source/clock_activity_monitor.sv
source/clock_ctrl.sv
dv/clock_ctrl_tb.sv

/* source/clock_activity_monitor.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_activity_monitor #(
	parameter int n_inputs = clock_ctrl_pkg::num_mon	// Inputs watched
) (
	input  wire logic                clock,
	input  wire logic                rst_n,
	input  wire logic [n_inputs-1:0] clocks_in,		// Spare clock pins
	output logic      [n_inputs-1:0] running		// Pseudo-lock per input
);

//---------------------------------------------------------------------------
// Dual-edge samples
//---------------------------------------------------------------------------
	logic [n_inputs-1:0] rise_q;	// Taken on rising edge
	logic [n_inputs-1:0] fall_q;	// Taken on falling edge

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			rise_q <= '0;
		end else begin
			rise_q <= clocks_in;
		end
	end

	// Reset seen on the falling edge too, so both halves clear together
	always_ff @(negedge clock) begin
		if (!rst_n) begin
			fall_q <= '0;
		end else begin
			fall_q <= clocks_in;
		end
	end

//---------------------------------------------------------------------------
// Running flag
//---------------------------------------------------------------------------
	// Running input at clock rate differs between half cycles
	// Stuck high or low gives equal samples
	assign running = rise_q ^ fall_q;

endmodule

`default_nettype wire

/* source/clock_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module clock_ctrl (
	input  wire logic                                                  clock,
	input  wire logic                                                  rst_n,
	input  wire clock_ctrl_pkg::dps_ctrl_t [clock_ctrl_pkg::num_dps-1:0] dps_ctrl,
	output wire clock_ctrl_pkg::dps_stat_t [clock_ctrl_pkg::num_dps-1:0] dps_stat,
	output wire clock_ctrl_pkg::ps_cmd_t   [clock_ctrl_pkg::num_dps-1:0] ps_cmd,
	input  wire logic [clock_ctrl_pkg::num_dps-1:0]                    ps_done,
	input  wire logic [clock_ctrl_pkg::num_dps-1:0]                    dps_lock,
	input  wire logic                                                  lock_main,
	input  wire logic                                                  global_reset_en,
	output wire logic                                                  global_reset,
	output wire logic                                                  clock_lock_lost_err,
	input  wire logic [clock_ctrl_pkg::num_mon-1:0]                    spare_clocks,
	output wire logic [clock_ctrl_pkg::num_mon-1:0]                    spare_lock
);

//---------------------------------------------------------------------------
// Global reset from main PLL lock
//---------------------------------------------------------------------------
	startup_reset u_startup_reset (
		.clock               (clock),
		.rst_n               (rst_n),
		.lock_main           (lock_main),			// Main PLL lock input
		.global_reset_en     (global_reset_en),		// Re-fire enable
		.global_reset        (global_reset),		// Fans out to shifters
		.clock_lock_lost_err (clock_lock_lost_err)
	);

//---------------------------------------------------------------------------
// Pseudo-lock for spare clock inputs
//---------------------------------------------------------------------------
	clock_activity_monitor #(
		.n_inputs (clock_ctrl_pkg::num_mon)
	) u_activity_monitor (
		.clock     (clock),
		.rst_n     (rst_n),
		.clocks_in (spare_clocks),
		.running   (spare_lock)
	);

//---------------------------------------------------------------------------
// Phase shifters
//---------------------------------------------------------------------------
	// Channel 0 ALCT rx, 1 ALCT tx, 2-8 DCFEB0-6 rx
	for (genvar i = 0; i < clock_ctrl_pkg::num_dps; i++) begin : gen_dps
		phase_shifter u_phase_shifter (
			.clock        (clock),
			.rst_n        (rst_n),
			.global_reset (global_reset),
			.lock_main    (lock_main),
			.dps_lock     (dps_lock[i]),		// This channel's PLL lock
			.ctrl         (dps_ctrl[i]),		// VME command
			.ps_done      (ps_done[i]),			// PLL step done
			.cmd          (ps_cmd[i]),			// PLL enable and direction
			.stat         (dps_stat[i])			// VME status
		);
	end

endmodule

`default_nettype wire

/* source/clock_ctrl_pkg.sv */
`default_nettype none

package clock_ctrl_pkg;

//---------------------------------------------------------------------------
// Counts and widths
//---------------------------------------------------------------------------
	localparam int num_dps         = 9;		// 2 ALCT + 7 DCFEB shifters
	localparam int num_mon         = 7;		// Spare clock inputs watched
	localparam int phase_req_w     = 8;		// VME request, 0-255 per cycle
	localparam int phase_step_w    = 11;	// Fine phase, 0-1399
	localparam int steps_per_cycle = 1400;	// PLL fine steps in one clock period
	localparam int req_per_cycle   = 256;	// VME codes in one clock period

//---------------------------------------------------------------------------
// Phase types
//---------------------------------------------------------------------------
	typedef logic [phase_req_w-1:0]  phase_req_t;	// Coarse VME phase
	typedef logic [phase_step_w-1:0] phase_step_t;	// Fine PLL phase

	// Shifter FSM, values read back on the VME state vector
	typedef enum logic [2:0] {
		st_hold      = 3'd0,	// Waiting for locks and reset release
		st_idle      = 3'd1,	// Ready for a fire
		st_step      = 3'd2,	// Enable pulse toward PLL
		st_wait_done = 3'd3,	// Waiting on PLL done
		st_check     = 3'd4		// Compare current with target
	} dps_state_t;

//---------------------------------------------------------------------------
// Bundles
//---------------------------------------------------------------------------
	// VME command, one per channel
	typedef struct packed {
		logic       fire;		// One-cycle strobe, new phase
		logic       reset;		// Level, zero tracked phase
		phase_req_t phase;		// Requested phase 0-255
	} dps_ctrl_t;

	// VME status, one per channel
	typedef struct packed {
		logic       busy;		// Shift in progress
		dps_state_t state;		// FSM state
	} dps_stat_t;

	// Toward the channel PLL
	typedef struct packed {
		logic en;				// Shift enable, one cycle
		logic incdec;			// 1 = increment
	} ps_cmd_t;

//---------------------------------------------------------------------------
// Request to fine step translation
//---------------------------------------------------------------------------
	// Nearest integer of req*1400/256, halves round up
	function automatic phase_step_t to_steps(input phase_req_t req);
		int scaled;
		scaled = int'(req) * steps_per_cycle;	// Max 357000, fits in int
		scaled = scaled + req_per_cycle / 2;	// Rounding offset
		return phase_step_t'(scaled / req_per_cycle);
	endfunction

endpackage

`default_nettype wire

/* source/phase_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module phase_shifter (
	input  wire logic                      clock,
	input  wire logic                      rst_n,
	input  wire logic                      global_reset,	// Held until main PLL locks
	input  wire logic                      lock_main,		// Main PLL lock
	input  wire logic                      dps_lock,		// This channel's PLL lock
	input  wire clock_ctrl_pkg::dps_ctrl_t ctrl,			// VME fire, reset, phase
	input  wire logic                      ps_done,			// PLL step finished
	output clock_ctrl_pkg::ps_cmd_t        cmd,				// PLL enable and direction
	output clock_ctrl_pkg::dps_stat_t      stat				// VME busy and state
);

//---------------------------------------------------------------------------
// Channel state
//---------------------------------------------------------------------------
	clock_ctrl_pkg::dps_state_t  state;		// FSM
	logic                        busy;		// Fire accepted, not yet done
	logic                        incdec;	// Direction of pending step
	clock_ctrl_pkg::phase_step_t target;	// Requested fine phase
	clock_ctrl_pkg::phase_step_t current;	// Tracked PLL phase

	wire lock_ok = lock_main && dps_lock;	// Both PLLs locked

//---------------------------------------------------------------------------
// FSM
//---------------------------------------------------------------------------
	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state   <= clock_ctrl_pkg::st_hold;
			busy    <= 1'b0;
			incdec  <= 1'b0;
			current <= '0;
		end else if (ctrl.reset) begin
			state   <= clock_ctrl_pkg::st_hold;	// Park while reset level high
			busy    <= 1'b0;
			current <= '0;						// PLL restarts at zero phase
		end else if (global_reset || !lock_ok) begin
			state <= clock_ctrl_pkg::st_hold;	// Lost lock, keep current
			busy  <= 1'b0;
		end else begin
			case (state)
				clock_ctrl_pkg::st_hold: begin
					state <= clock_ctrl_pkg::st_idle;	// All locks good
				end
				clock_ctrl_pkg::st_idle: begin
					if (ctrl.fire) begin
						busy  <= 1'b1;
						state <= clock_ctrl_pkg::st_check;
					end
				end
				clock_ctrl_pkg::st_check: begin
					if (current == target) begin
						busy  <= 1'b0;					// Arrived
						state <= clock_ctrl_pkg::st_idle;
					end else begin
						incdec <= (target > current);	// Up if below target
						state  <= clock_ctrl_pkg::st_step;
					end
				end
				clock_ctrl_pkg::st_step: begin
					state <= clock_ctrl_pkg::st_wait_done;	// En lasts this cycle only
				end
				clock_ctrl_pkg::st_wait_done: begin
					if (ps_done) begin
						current <= incdec ? current + 1'b1 : current - 1'b1;
						state   <= clock_ctrl_pkg::st_check;
					end
				end
				default: begin
					state <= clock_ctrl_pkg::st_hold;	// Unused codes
				end
			endcase
		end
	end

	// Target latched only when a fire is taken, phase sampled same cycle
	always_ff @(posedge clock) begin
		if (state == clock_ctrl_pkg::st_idle && ctrl.fire) begin
			target <= clock_ctrl_pkg::to_steps(ctrl.phase);
		end
	end

//---------------------------------------------------------------------------
// Outputs
//---------------------------------------------------------------------------
	always_comb begin
		cmd.en     = (state == clock_ctrl_pkg::st_step);	// Decoded from state flop
		cmd.incdec = incdec;
		stat.busy  = busy;
		stat.state = state;
	end

//---------------------------------------------------------------------------
// Checks
//---------------------------------------------------------------------------
	// PLL sees a single-cycle enable per step
	a_en_one_cycle : assert property (@(posedge clock) disable iff (!rst_n)
		cmd.en |=> !cmd.en);

	// No stepping outside an accepted request
	a_en_busy : assert property (@(posedge clock) disable iff (!rst_n)
		cmd.en |-> busy);

	// Tracked phase stays inside one clock period
	a_current_range : assert property (@(posedge clock) disable iff (!rst_n)
		current <= clock_ctrl_pkg::phase_step_t'(clock_ctrl_pkg::steps_per_cycle - 1));

endmodule

`default_nettype wire

/* source/startup_reset.sv */
`timescale 1ns/1ps
`default_nettype none

module startup_reset (
	input  wire logic clock,
	input  wire logic rst_n,
	input  wire logic lock_main,			// Main PLL lock
	input  wire logic global_reset_en,		// Re-fire on lock loss
	output logic      global_reset,			// Held until first lock
	output logic      clock_lock_lost_err	// Lock gone after startup
);

//---------------------------------------------------------------------------
// First-lock memory and reset flop
//---------------------------------------------------------------------------
	logic startup_done;							// Set on first lock and stays set

	wire first_lock = lock_main || startup_done;	// Locked now or before

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			startup_done <= 1'b0;
			global_reset <= 1'b1;					// Hold everything off
		end else begin
			startup_done <= first_lock;
			global_reset <= !first_lock || (!lock_main && global_reset_en);
		end
	end

	// Lost lock seen while system is running
	assign clock_lock_lost_err = !global_reset && !lock_main;

//---------------------------------------------------------------------------
// Checks
//---------------------------------------------------------------------------
	// Nothing leaves reset before the main PLL has locked once
	a_hold_until_lock : assert property (@(posedge clock) disable iff (!rst_n)
		!startup_done |-> global_reset);

endmodule

`default_nettype wire
